/* common/pp_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Matrix-vector engine shared definitions
// Operand and accumulator types, widths and the
// read state encoding of the ping-pong controller
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package pp_pkg;

    // Operand element width, also sizes the packed north words
    localparam int ELEM_W = 8;

    // Enough headroom for INNER_DIM up to 16 at full scale
    localparam int ACC_W = 20;

    typedef logic signed [ELEM_W-1:0] elem_t;

    typedef logic signed [ACC_W-1:0] acc_t;

    // Read side of the ping-pong controller
    typedef enum logic [1:0] {
        pp_read_idle,
        pp_reading,
        pp_draining
    } rd_state_t;

endpackage

/* design/bank_ram.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bank RAM
// Single-port synchronous memory, one-cycle read
// latency, payload given as a type parameter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module bank_ram #(
    parameter type word_t = logic [7:0],
    parameter int  DEPTH  = 8,
    localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  logic              clk,
    input  logic              en,
    input  logic              we,
    input  logic [ADDR_W-1:0] addr,
    input  word_t             wdata,
    output word_t             rdata
);

    word_t mem [DEPTH];

    // Write has priority, read data only updates on a read access
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

/* design/mac_array.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MAC array
// COL_Y signed multiply-accumulate lanes, one
// result vector and a valid pulse per job
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module mac_array #(
    parameter int  COL_Y = 2,
    localparam int N_W   = COL_Y * pp_pkg::ELEM_W,
    localparam int RES_W = COL_Y * pp_pkg::ACC_W
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             mac_en,
    input  logic             mac_first,
    input  logic             mac_last,

    input  pp_pkg::elem_t    rd_w_word,
    input  logic [N_W-1:0]   rd_n_word,

    output logic [RES_W-1:0] result,
    output logic             out_valid,
    output logic             acc_done
);

    pp_pkg::acc_t acc_q    [COL_Y];
    pp_pkg::acc_t result_q [COL_Y];
    logic         valid_q;

    for (genvar j = 0; j < COL_Y; j++) begin : g_lane
        pp_pkg::elem_t                   n_elem;
        logic signed [2*pp_pkg::ELEM_W-1:0] prod;
        pp_pkg::acc_t                    sum;

        assign n_elem = pp_pkg::elem_t'(rd_n_word[j*pp_pkg::ELEM_W +: pp_pkg::ELEM_W]);
        assign prod   = rd_w_word * n_elem;

        // First row starts a fresh sum
        assign sum = mac_first ? pp_pkg::acc_t'(prod) : acc_q[j] + prod;

        always_ff @(posedge clk) begin
            if (mac_en) begin
                acc_q[j] <= sum;
            end
        end

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                result_q[j] <= '0;
            end else if (mac_en && mac_last) begin
                result_q[j] <= sum;
            end
        end

        assign result[j*pp_pkg::ACC_W +: pp_pkg::ACC_W] = result_q[j];
    end

    // Single-cycle pulse on the cycle after the last row
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= mac_en && mac_last;
        end
    end

    assign out_valid = valid_q;
    assign acc_done  = valid_q;

endmodule

/* design/matvec_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Matrix-vector engine top level
// Ping-pong buffer, its controller and the MAC
// array, one result vector per streamed job
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module matvec_top #(
    parameter int  INNER_DIM = 8,
    parameter int  COL_Y     = 2,
    localparam int ADDR_W    = (INNER_DIM > 1) ? $clog2(INNER_DIM) : 1,
    localparam int N_W       = COL_Y * pp_pkg::ELEM_W,
    localparam int RES_W     = COL_Y * pp_pkg::ACC_W
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  pp_pkg::elem_t    w_data,
    input  logic [N_W-1:0]   n_data,
    output logic             buf_full,
    output logic             out_valid,
    output logic [RES_W-1:0] result
);

    logic              wr_en;
    logic              wr_bank_sel;
    logic [ADDR_W-1:0] wr_addr;
    logic              rd_bank_sel;
    logic [ADDR_W-1:0] rd_addr;
    logic              mac_en;
    logic              mac_first;
    logic              mac_last;
    logic              acc_done;
    pp_pkg::elem_t     rd_w_word;
    logic [N_W-1:0]    rd_n_word;

    ping_pong_ctrl #(
        .INNER_DIM (INNER_DIM)
    ) u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .acc_done    (acc_done),
        .wr_en       (wr_en),
        .wr_bank_sel (wr_bank_sel),
        .wr_addr     (wr_addr),
        .rd_bank_sel (rd_bank_sel),
        .rd_addr     (rd_addr),
        .mac_en      (mac_en),
        .mac_first   (mac_first),
        .mac_last    (mac_last),
        .buf_full    (buf_full)
    );

    ping_pong_buffer #(
        .INNER_DIM (INNER_DIM),
        .COL_Y     (COL_Y)
    ) u_buffer (
        .clk         (clk),
        .wr_en       (wr_en),
        .wr_bank_sel (wr_bank_sel),
        .wr_addr     (wr_addr),
        .w_data      (w_data),
        .n_data      (n_data),
        .rd_bank_sel (rd_bank_sel),
        .rd_addr     (rd_addr),
        .rd_w_word   (rd_w_word),
        .rd_n_word   (rd_n_word)
    );

    mac_array #(
        .COL_Y (COL_Y)
    ) u_mac (
        .clk       (clk),
        .rst_n     (rst_n),
        .mac_en    (mac_en),
        .mac_first (mac_first),
        .mac_last  (mac_last),
        .rd_w_word (rd_w_word),
        .rd_n_word (rd_n_word),
        .result    (result),
        .out_valid (out_valid),
        .acc_done  (acc_done)
    );

endmodule

/* list.f */
common/pp_pkg.sv
design/bank_ram.sv
ping_pong/ping_pong_ctrl.sv
ping_pong/ping_pong_buffer.sv
design/mac_array.sv
design/matvec_top.sv
test/tb_clock.sv
test/matvec_asserts.sv
test/matvec_tb.sv

/* ping_pong/ping_pong_buffer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Ping-pong operand buffer
// Two banks of west and north RAMs, writes go to
// the loading bank, reads come from the other one
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module ping_pong_buffer #(
    parameter int  INNER_DIM = 8,
    parameter int  COL_Y     = 2,
    localparam int ADDR_W    = (INNER_DIM > 1) ? $clog2(INNER_DIM) : 1,
    localparam int N_W       = COL_Y * pp_pkg::ELEM_W
) (
    input  logic              clk,

    input  logic              wr_en,
    input  logic              wr_bank_sel,
    input  logic [ADDR_W-1:0] wr_addr,
    input  pp_pkg::elem_t     w_data,
    input  logic [N_W-1:0]    n_data,

    input  logic              rd_bank_sel,
    input  logic [ADDR_W-1:0] rd_addr,
    output pp_pkg::elem_t     rd_w_word,
    output logic [N_W-1:0]    rd_n_word
);

    pp_pkg::elem_t  w_rdata [2];
    logic [N_W-1:0] n_rdata [2];

    // Bank select of the read issued last cycle
    logic rd_sel_q;

    for (genvar b = 0; b < 2; b++) begin : g_bank
        logic              bank_we;
        logic              bank_en;
        logic [ADDR_W-1:0] bank_addr;

        assign bank_we   = wr_en && (wr_bank_sel == 1'(b));
        assign bank_en   = bank_we || (rd_bank_sel == 1'(b));
        assign bank_addr = bank_we ? wr_addr : rd_addr;

        bank_ram #(
            .word_t (pp_pkg::elem_t),
            .DEPTH  (INNER_DIM)
        ) u_w_ram (
            .clk   (clk),
            .en    (bank_en),
            .we    (bank_we),
            .addr  (bank_addr),
            .wdata (w_data),
            .rdata (w_rdata[b])
        );

        // North row packs COL_Y elements in one word
        bank_ram #(
            .word_t (logic [N_W-1:0]),
            .DEPTH  (INNER_DIM)
        ) u_n_ram (
            .clk   (clk),
            .en    (bank_en),
            .we    (bank_we),
            .addr  (bank_addr),
            .wdata (n_data),
            .rdata (n_rdata[b])
        );
    end

    always_ff @(posedge clk) begin
        rd_sel_q <= rd_bank_sel;
    end

    assign rd_w_word = w_rdata[rd_sel_q];
    assign rd_n_word = n_rdata[rd_sel_q];

endmodule

/* ping_pong/ping_pong_ctrl.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Ping-pong controller
// Tracks which bank is loading and which is read,
// generates write and read addresses and the MAC
// strobes, and sequences jobs in arrival order
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module ping_pong_ctrl #(
    parameter int  INNER_DIM = 8,
    localparam int ADDR_W    = (INNER_DIM > 1) ? $clog2(INNER_DIM) : 1
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  logic              acc_done,

    output logic              wr_en,
    output logic              wr_bank_sel,
    output logic [ADDR_W-1:0] wr_addr,

    output logic              rd_bank_sel,
    output logic [ADDR_W-1:0] rd_addr,

    output logic              mac_en,
    output logic              mac_first,
    output logic              mac_last,

    output logic              buf_full
);

    localparam logic [ADDR_W-1:0] LAST_ROW = ADDR_W'(INNER_DIM - 1);

    // One bit per bank, set when the bank holds a complete unread job
    logic [1:0] full_q;
    logic [1:0] full_d;

    logic              wr_bank_q;
    logic [ADDR_W-1:0] wr_cnt_q;

    logic              rd_bank_q;
    logic [ADDR_W-1:0] rd_cnt_q;

    pp_pkg::rd_state_t rd_state_q;
    pp_pkg::rd_state_t rd_state_d;

    logic wr_last;
    logic rd_last;
    logic rd_free;

    // Strobes delayed by one cycle to line up with RAM read data
    logic mac_en_q;
    logic mac_first_q;
    logic mac_last_q;

    // Write side
    assign buf_full = full_q[wr_bank_q];
    assign wr_en    = in_valid & ~buf_full;
    assign wr_last  = wr_en && (wr_cnt_q == LAST_ROW);

    // Read side
    assign rd_last = (rd_state_q == pp_pkg::pp_reading) && (rd_cnt_q == LAST_ROW);
    assign rd_free = (rd_state_q == pp_pkg::pp_draining) && acc_done;

    always_comb begin
        rd_state_d = rd_state_q;
        case (rd_state_q)
            pp_pkg::pp_read_idle: begin
                if (full_q[rd_bank_q]) begin
                    rd_state_d = pp_pkg::pp_reading;
                end
            end
            pp_pkg::pp_reading: begin
                if (rd_last) begin
                    rd_state_d = pp_pkg::pp_draining;
                end
            end
            pp_pkg::pp_draining: begin
                // Chain straight into the other bank when it is already loaded
                if (acc_done) begin
                    if (full_q[!rd_bank_q]) begin
                        rd_state_d = pp_pkg::pp_reading;
                    end else begin
                        rd_state_d = pp_pkg::pp_read_idle;
                    end
                end
            end
            default: begin
                rd_state_d = pp_pkg::pp_read_idle;
            end
        endcase
    end

    // Set and clear never hit the same bank, a full bank blocks writes
    always_comb begin
        full_d = full_q;
        if (wr_last) begin
            full_d[wr_bank_q] = 1'b1;
        end
        if (rd_free) begin
            full_d[rd_bank_q] = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            full_q      <= 2'b00;
            wr_bank_q   <= 1'b0;
            wr_cnt_q    <= '0;
            rd_bank_q   <= 1'b0;
            rd_cnt_q    <= '0;
            rd_state_q  <= pp_pkg::pp_read_idle;
            mac_en_q    <= 1'b0;
            mac_first_q <= 1'b0;
            mac_last_q  <= 1'b0;
        end else begin
            full_q     <= full_d;
            rd_state_q <= rd_state_d;

            if (wr_en) begin
                if (wr_last) begin
                    wr_cnt_q  <= '0;
                    wr_bank_q <= ~wr_bank_q;
                end else begin
                    wr_cnt_q <= wr_cnt_q + 1'b1;
                end
            end

            // Address wraps to zero so the next job starts at row 0
            if (rd_state_q == pp_pkg::pp_reading) begin
                if (rd_last) begin
                    rd_cnt_q <= '0;
                end else begin
                    rd_cnt_q <= rd_cnt_q + 1'b1;
                end
            end

            if (rd_free) begin
                rd_bank_q <= ~rd_bank_q;
            end

            mac_en_q    <= (rd_state_q == pp_pkg::pp_reading);
            mac_first_q <= (rd_state_q == pp_pkg::pp_reading) && (rd_cnt_q == '0);
            mac_last_q  <= rd_last;
        end
    end

    assign wr_bank_sel = wr_bank_q;
    assign wr_addr     = wr_cnt_q;
    assign rd_bank_sel = rd_bank_q;
    assign rd_addr     = rd_cnt_q;
    assign mac_en      = mac_en_q;
    assign mac_first   = mac_first_q;
    assign mac_last    = mac_last_q;

endmodule

/* test/matvec_asserts.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Ping-pong controller assertions
// Bound into every ping_pong_ctrl instance
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module matvec_asserts #(
    parameter int  INNER_DIM = 8,
    localparam int ADDR_W    = (INNER_DIM > 1) ? $clog2(INNER_DIM) : 1
) (
    input logic              clk,
    input logic              rst_n,
    input logic              in_valid,
    input logic              wr_en,
    input logic              buf_full,
    input logic              wr_bank_sel,
    input logic [ADDR_W-1:0] wr_addr,
    input logic              acc_done,
    input pp_pkg::rd_state_t rd_state,
    input logic              mac_en,
    input logic              mac_first,
    input logic              mac_last
);

    localparam logic [ADDR_W-1:0] LAST_ROW = ADDR_W'(INNER_DIM - 1);

    // Read by the testbench at the end of the run
    int fail_count;

    initial fail_count = 0;

    // A row must never target a bank that still holds an unread job
    no_write_when_full: assert property (
        @(posedge clk) disable iff (!rst_n) (in_valid || wr_en) |-> !buf_full
    ) else begin
        fail_count++;
        $error("Row written while buf_full is high");
    end

    no_done_when_idle: assert property (
        @(posedge clk) disable iff (!rst_n) acc_done |-> (rd_state != pp_pkg::pp_read_idle)
    ) else begin
        fail_count++;
        $error("acc_done seen with the read machine idle");
    end

    strobes_need_enable: assert property (
        @(posedge clk) disable iff (!rst_n) (mac_first || mac_last) |-> mac_en
    ) else begin
        fail_count++;
        $error("mac_first or mac_last high without mac_en");
    end

    // Reset itself moves the bank pointer back to zero
    bank_toggle_on_last_row: assert property (
        @(posedge clk) disable iff (!rst_n)
            ($past(rst_n) && $changed(wr_bank_sel)) |-> $past(wr_en && (wr_addr == LAST_ROW))
    ) else begin
        fail_count++;
        $error("wr_bank_sel changed without a last-row write");
    end

endmodule

bind ping_pong_ctrl matvec_asserts #(
    .INNER_DIM (INNER_DIM)
) u_asserts (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .wr_en       (wr_en),
    .buf_full    (buf_full),
    .wr_bank_sel (wr_bank_sel),
    .wr_addr     (wr_addr),
    .acc_done    (acc_done),
    .rd_state    (rd_state_q),
    .mac_en      (mac_en),
    .mac_first   (mac_first),
    .mac_last    (mac_last)
);

/* test/matvec_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Matrix-vector engine testbench
// Streams a table of jobs, checks every result
// vector against plain signed dot products
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module matvec_tb;

    localparam int INNER_DIM = 8;
    localparam int COL_Y     = 2;
    localparam int N_W       = COL_Y * pp_pkg::ELEM_W;
    localparam int RES_W     = COL_Y * pp_pkg::ACC_W;
    localparam int NJOBS     = 12;
    localparam int WAIT_MAX  = 20 * INNER_DIM + 50;

    logic             clk;
    logic             por_n;
    logic             ctl_rst_n;
    logic             rst_n;
    logic             in_valid;
    pp_pkg::elem_t    w_data;
    logic [N_W-1:0]   n_data;
    logic             buf_full;
    logic             out_valid;
    logic [RES_W-1:0] result;

    // Job table
    string         job_name [NJOBS];
    pp_pkg::elem_t job_w    [NJOBS][INNER_DIM];
    pp_pkg::elem_t job_n    [NJOBS][INNER_DIM][COL_Y];
    int            job_gap  [NJOBS];
    bit            job_rst  [NJOBS];
    bit            job_lat  [NJOBS];
    bit            job_full [NJOBS];

    // Jobs loaded but not yet answered, oldest first
    int pend_q   [$];
    int pend_cyc [$];

    int seed;
    int cyc;
    int done_count;

    assign rst_n = por_n & ctl_rst_n;

    tb_clock u_clock (
        .clk   (clk),
        .rst_n (por_n)
    );

    matvec_top #(
        .INNER_DIM (INNER_DIM),
        .COL_Y     (COL_Y)
    ) UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .w_data    (w_data),
        .n_data    (n_data),
        .buf_full  (buf_full),
        .out_valid (out_valid),
        .result    (result)
    );

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected !== actual) begin
            $display("FAIL %s expected %0d actual %0d", name, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Timed out while waiting for %s", what);
        $display("ERRORS FOUND");
        $fatal(1, "Stopped on a timeout");
    endtask

    function automatic int dot_product(input int idx, input int j);
        int sum;
        sum = 0;
        for (int k = 0; k < INNER_DIM; k++) begin
            sum += int'(job_w[idx][k]) * int'(job_n[idx][k][j]);
        end
        return sum;
    endfunction

    function automatic logic [N_W-1:0] north_word(input int idx, input int k);
        logic [N_W-1:0] word;
        for (int j = 0; j < COL_Y; j++) begin
            word[j*pp_pkg::ELEM_W +: pp_pkg::ELEM_W] = job_n[idx][k][j];
        end
        return word;
    endfunction

    task automatic set_job(input int idx, input string name, input int gap,
                           input bit rst, input bit lat, input bit full);
        job_name[idx] = name;
        job_gap[idx]  = gap;
        job_rst[idx]  = rst;
        job_lat[idx]  = lat;
        job_full[idx] = full;
    endtask

    task automatic build_table;
        set_job(0, "small_pos", 2, 0, 1, 0);
        set_job(1, "neg_max", 3, 0, 0, 0);
        set_job(2, "mixed_sign", 1, 0, 0, 0);
        set_job(3, "b2b_first", 20, 0, 0, 0);
        set_job(4, "b2b_second", 0, 0, 0, 0);
        set_job(5, "burst_a", 20, 0, 0, 0);
        set_job(6, "burst_b", 0, 0, 0, 0);
        set_job(7, "burst_c", 0, 0, 0, 1);
        set_job(8, "reset_mid", 2, 1, 1, 0);
        for (int i = 9; i < NJOBS; i++) begin
            set_job(i, $sformatf("random_%0d", i - 9), $unsigned($random(seed)) % 5, 0, 0, 0);
        end
        for (int k = 0; k < INNER_DIM; k++) begin
            job_w[0][k] = pp_pkg::elem_t'(k + 1);
            job_w[1][k] = -8'sd128;
            job_w[2][k] = k[0] ? 8'sd127 : -8'sd128;
            job_w[3][k] = pp_pkg::elem_t'(k - 4);
            job_w[4][k] = pp_pkg::elem_t'(100 - 25 * k);
            for (int j = 0; j < COL_Y; j++) begin
                job_n[0][k][j] = pp_pkg::elem_t'(2 * k + j + 1);
                job_n[1][k][j] = -8'sd128;
                job_n[2][k][j] = (k[0] ^ j[0]) ? -8'sd128 : 8'sd127;
                job_n[3][k][j] = pp_pkg::elem_t'(3 * k - 5 * j - 7);
                job_n[4][k][j] = pp_pkg::elem_t'(9 * k + j - 30);
            end
            for (int i = 5; i < NJOBS; i++) begin
                job_w[i][k] = pp_pkg::elem_t'($random(seed));
                for (int j = 0; j < COL_Y; j++) begin
                    job_n[i][k][j] = pp_pkg::elem_t'($random(seed));
                end
            end
        end
    endtask

    task automatic drive_row(input pp_pkg::elem_t w, input logic [N_W-1:0] n);
        in_valid <= 1'b1;
        w_data   <= w;
        n_data   <= n;
    endtask

    // Returns on the edge where row 0 may be driven
    task automatic wait_for_space(output int full_seen);
        int  waited;
        bit  space;
        waited    = 0;
        full_seen = 0;
        space     = 1'b0;
        while (!space) begin
            @(posedge clk);
            // Just after a last row the other bank is free once no older job is pending
            if (in_valid) begin
                space = (pend_q.size() == 1);
            end else begin
                space = !buf_full;
                if (buf_full) begin
                    full_seen++;
                end
            end
            if (!space) begin
                in_valid <= 1'b0;
                waited++;
                if (waited > WAIT_MAX) begin
                    timeout_fail("buf_full to fall");
                end
            end
        end
    endtask

    task automatic wait_drain(input string what);
        int waited;
        waited = 0;
        while (pend_q.size() != 0) begin
            @(posedge clk);
            in_valid <= 1'b0;
            waited++;
            if (waited > WAIT_MAX) begin
                timeout_fail(what);
            end
        end
    endtask

    task automatic run_job(input int idx);
        int full_seen;
        if (job_rst[idx]) begin
            wait_drain("results before the reset job");
            wait_for_space(full_seen);
            // Half a job of rows that the reset must discard
            for (int k = 0; k < INNER_DIM / 2; k++) begin
                if (k > 0) begin
                    @(posedge clk);
                end
                drive_row(pp_pkg::elem_t'(8'h55 ^ k), ~north_word(idx, k));
            end
            @(posedge clk);
            in_valid  <= 1'b0;
            ctl_rst_n <= 1'b0;
            repeat (2) @(posedge clk);
            ctl_rst_n <= 1'b1;
            @(negedge clk);
            check_value({job_name[idx], " out_valid after reset"}, 0, int'(out_valid));
            check_value({job_name[idx], " buf_full after reset"}, 0, int'(buf_full));
        end
        for (int g = 0; g < job_gap[idx]; g++) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
        wait_for_space(full_seen);
        if (job_full[idx]) begin
            check_value({job_name[idx], " waited on buf_full"}, 1, int'(full_seen > 0));
        end
        for (int k = 0; k < INNER_DIM; k++) begin
            if (k > 0) begin
                @(posedge clk);
            end
            drive_row(job_w[idx][k], north_word(idx, k));
        end
        pend_q.push_back(idx);
        // Cycle number in which the last row is presented
        pend_cyc.push_back(cyc + 1);
    endtask

    // Pairs each result pulse with the oldest outstanding job
    always @(negedge clk) begin
        int idx;
        int row_cyc;
        if (rst_n && out_valid) begin
            if (pend_q.size() == 0) begin
                $display("out_valid pulsed with no job outstanding");
                $display("ERRORS FOUND");
                $fatal(1, "Stopped on an unexpected result");
            end
            idx     = pend_q.pop_front();
            row_cyc = pend_cyc.pop_front();
            for (int j = 0; j < COL_Y; j++) begin
                check_value($sformatf("%s lane %0d", job_name[idx], j), dot_product(idx, j),
                            int'(pp_pkg::acc_t'(result[j*pp_pkg::ACC_W +: pp_pkg::ACC_W])));
            end
            if (job_lat[idx]) begin
                check_value({job_name[idx], " latency"}, INNER_DIM + 3, cyc - row_cyc);
            end
            done_count++;
        end
    end

    initial begin
        int waited;
        in_valid   = 1'b0;
        w_data     = '0;
        n_data     = '0;
        ctl_rst_n  = 1'b1;
        seed       = 32'h5515_92d7;
        cyc        = 0;
        done_count = 0;
        waited     = 0;
        build_table();
        @(posedge clk);
        while (!rst_n) begin
            waited++;
            if (waited > 20) begin
                timeout_fail("the power-on reset to end");
            end
            @(posedge clk);
        end
        for (int i = 0; i < NJOBS; i++) begin
            run_job(i);
        end
        @(posedge clk);
        in_valid <= 1'b0;
        wait_drain("the final results");
        check_value("result count", NJOBS, done_count);
        if (UUT.u_ctrl.u_asserts.fail_count == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("ERRORS FOUND");
            $fatal(1, "Assertion failures were reported");
        end
    end

endmodule

/* test/tb_clock.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and power-on reset
// 100 ns clock, reset held low for 5 cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_clock #(
    parameter realtime PERIOD      = 100ns,
    parameter int      RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Released on a rising edge like any other driven input
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule
